/* design/serial_bus_defs.svh */
// widths and depth macros for the serial bus
`ifndef SERIAL_BUS_DEFS_SVH
`define SERIAL_BUS_DEFS_SVH

// address bits carried per frame
// sent lsb first on the address line
`define SB_ADDR_WIDTH 12

// data bits carried per frame
// sent lsb first on the data line, same cycles as the address
// also the width of a read response
`define SB_DATA_WIDTH 8

// bytes in the slave memory
// one byte per address, so 2**SB_ADDR_WIDTH
`define SB_MEM_DEPTH 4096

// bit counters are sized from these with $clog2
// in the modules that use them
// memory contents are never cleared by reset

`endif

/* design/serial_bus_pkg.sv */
// opcode enum, state enums and shared structs for the serial bus
`include "serial_bus_defs.svh"

package serial_bus_pkg;

	// single opcode bit replaces separate read and write enables
	typedef enum logic {OP_READ = 1'b0, OP_WRITE = 1'b1} bus_op_e;

	// command as handed over by the host
	typedef struct packed {
		bus_op_e op;
		logic [`SB_ADDR_WIDTH-1:0] addr;
		logic [`SB_DATA_WIDTH-1:0] wdata;
	} host_cmd_t;

	// master to slave lines
	typedef struct packed {
		logic valid;
		bus_op_e op;
		logic addr_bit;
		logic data_bit;
	} serial_fwd_t;

	// slave to master lines
	typedef struct packed {
		logic ready;
		logic valid;
		logic data_bit;
	} serial_rev_t;

	// frame as rebuilt by the slave input port
	typedef struct packed {
		bus_op_e op;
		logic [`SB_ADDR_WIDTH-1:0] addr;
		logic [`SB_DATA_WIDTH-1:0] data;
	} bus_frame_t;

	// one state per address bit, one per data bit
	typedef enum logic [3:0] {ADDR_IDLE, ADDR1, ADDR2, ADDR3, ADDR4, ADDR5, ADDR6,
		ADDR7, ADDR8, ADDR9, ADDR10, ADDR11, ADDR12} addr_state_e;
	typedef enum logic [3:0] {DATA_IDLE, DATA1, DATA2, DATA3, DATA4, DATA5, DATA6,
		DATA7, DATA8} data_state_e;

	// master sequencing
	typedef enum logic [2:0] {M_IDLE, M_WAIT_READY, M_SEND, M_WAIT_RESP, M_RECV,
		M_ACK} mport_state_e;

endpackage

/* design/master_port.sv */
// master port: host req/ack handshake, command serializer, read data deserializer
`timescale 1ns/1ns
`include "serial_bus_defs.svh"

module master_port (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        host_req,
	input  serial_bus_pkg::host_cmd_t   host_cmd,
	output logic                        host_ack,
	output logic [`SB_DATA_WIDTH-1:0]   host_rdata,
	output serial_bus_pkg::serial_fwd_t fwd,
	input  serial_bus_pkg::serial_rev_t rev
);

	import serial_bus_pkg::*;

	// counter covers the longer address field
	localparam int CNT_W = $clog2(`SB_ADDR_WIDTH);
	localparam int DCNT_W = $clog2(`SB_DATA_WIDTH);

	mport_state_e state;
	host_cmd_t cmd;
	logic [CNT_W-1:0] bit_cnt;
	logic last_addr_bit;
	logic last_rx_bit;

	assign last_addr_bit = (bit_cnt == CNT_W'(`SB_ADDR_WIDTH - 1));
	assign last_rx_bit = (bit_cnt == CNT_W'(`SB_DATA_WIDTH - 1));

	// ack is a plain state decode
	assign host_ack = (state == M_ACK);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= M_IDLE;
			bit_cnt <= '0;
		end
		else
		begin
			case (state)
				M_IDLE:
					if (host_req)
						state <= M_WAIT_READY;
				// valid is up here, leave on the handshake cycle
				M_WAIT_READY:
					if (rev.ready)
					begin
						state <= M_SEND;
						bit_cnt <= '0;
					end
				// one address bit per cycle, data rides along for the first 8
				M_SEND:
				begin
					bit_cnt <= bit_cnt + 1'b1;
					if (last_addr_bit)
					begin
						if (cmd.op == OP_WRITE)
							state <= M_ACK;
						else
							state <= M_WAIT_RESP;
					end
				end
				// response starts with a lone valid cycle
				M_WAIT_RESP:
					if (rev.valid)
					begin
						state <= M_RECV;
						bit_cnt <= '0;
					end
				M_RECV:
				begin
					bit_cnt <= bit_cnt + 1'b1;
					if (last_rx_bit)
						state <= M_ACK;
				end
				// hold ack until the host drops req
				M_ACK:
					if (!host_req)
						state <= M_IDLE;
				default:
					state <= M_IDLE;
			endcase
		end
	end

	// command copy, host may change it once ack is seen
	always_ff @(posedge clk)
	begin
		if (state == M_IDLE && host_req)
			cmd <= host_cmd;
	end

	// read data, lsb arrives first
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			host_rdata <= '0;
		else if (state == M_RECV)
			host_rdata <= {rev.data_bit, host_rdata[`SB_DATA_WIDTH-1:1]};
	end

	// forward lines
	always_comb
	begin
		fwd = '0;
		fwd.valid = (state == M_WAIT_READY);
		fwd.op = cmd.op;
		if (state == M_SEND)
		begin
			fwd.addr_bit = cmd.addr[bit_cnt];
			// data line idles low after bit 7
			if (bit_cnt < CNT_W'(`SB_DATA_WIDTH))
				fwd.data_bit = cmd.wdata[bit_cnt[DCNT_W-1:0]];
		end
	end

	// four-phase: ack may only drop once req is gone
	assert property (@(posedge clk) disable iff (reset) $fell(host_ack) |-> !host_req)
		else $error("master_port: host_ack fell while host_req high");

endmodule

/* design/slave_in_port.sv */
// slave input port: address and data bit state machines rebuilding a frame
`timescale 1ns/1ns
`include "serial_bus_defs.svh"

module slave_in_port (
	input  logic                        clk,
	input  logic                        reset,
	input  serial_bus_pkg::serial_fwd_t fwd,
	input  logic                        resp_busy,
	output logic                        ready,
	output logic                        rx_done,
	output serial_bus_pkg::bus_frame_t  frame
);

	import serial_bus_pkg::*;

	addr_state_e addr_state;
	data_state_e data_state;
	logic handshake;

	// busy while either field is shifting in, a read is pending or a reply goes out
	assign ready = (addr_state == ADDR_IDLE) && (data_state == DATA_IDLE) &&
		!rx_done && !resp_busy;
	assign handshake = fwd.valid && ready;

	// address field, twelve bit states
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			addr_state <= ADDR_IDLE;
		else
		begin
			case (addr_state)
				ADDR_IDLE:
					if (handshake)
						addr_state <= ADDR1;
				ADDR12:
					addr_state <= ADDR_IDLE;
				default:
					addr_state <= addr_state_e'(addr_state + 4'd1);
			endcase
		end
	end

	// data field, eight bit states in parallel
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			data_state <= DATA_IDLE;
		else
		begin
			case (data_state)
				DATA_IDLE:
					if (handshake)
						data_state <= DATA1;
				DATA8:
					data_state <= DATA_IDLE;
				default:
					data_state <= data_state_e'(data_state + 4'd1);
			endcase
		end
	end

	// frame complete once the last address bit is in
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			rx_done <= 1'b0;
		else
			rx_done <= (addr_state == ADDR12);
	end

	// bit capture, state n takes bit n-1
	always_ff @(posedge clk)
	begin
		if (handshake)
			frame.op <= fwd.op;
		if (addr_state != ADDR_IDLE)
			frame.addr[addr_state - 4'd1] <= fwd.addr_bit;
		if (data_state != DATA_IDLE)
			frame.data[3'(data_state - 4'd1)] <= fwd.data_bit;
	end

	// done pulse only out of ADDR12, i.e. thirteen cycles after the handshake
	assert property (@(posedge clk) disable iff (reset) rx_done |-> $past(handshake, 13))
		else $error("slave_in_port: rx_done not 13 cycles after a handshake");

	// master keeps valid down while a frame is shifting in
	assert property (@(posedge clk) disable iff (reset) handshake |=> (!fwd.valid) [*12])
		else $error("slave_in_port: valid raised while receiving");

endmodule

/* design/slave_mem.sv */
// slave memory: byte array executing received frames, read response launch
`timescale 1ns/1ns
`include "serial_bus_defs.svh"

module slave_mem (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       rx_done,
	input  serial_bus_pkg::bus_frame_t frame,
	output logic                       resp_start,
	output logic [`SB_DATA_WIDTH-1:0]  resp_data
);

	import serial_bus_pkg::*;

	logic [`SB_DATA_WIDTH-1:0] mem [`SB_MEM_DEPTH];
	logic wr_hit;
	logic rd_hit;

	// frame is held stable while rx_done is high
	assign wr_hit = rx_done && (frame.op == OP_WRITE);
	assign rd_hit = rx_done && (frame.op == OP_READ);

	// write lands on the edge after rx_done
	// read byte registered at the same edge
	always_ff @(posedge clk)
	begin
		if (wr_hit)
			mem[frame.addr] <= frame.data;
		if (rd_hit)
			resp_data <= mem[frame.addr];
	end

	// one cycle kick to the output port
	// only reads get a response
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			resp_start <= 1'b0;
		else
			resp_start <= rd_hit;
	end

	// resp_data holds until the next read
	// output port copies it at resp_start anyway

endmodule

/* design/slave_out_port.sv */
// slave output port: read response serializer
`timescale 1ns/1ns
`include "serial_bus_defs.svh"

module slave_out_port (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      resp_start,
	input  logic [`SB_DATA_WIDTH-1:0] resp_data,
	output logic                      resp_busy,
	output logic                      rev_valid,
	output logic                      rev_data_bit
);

	// one valid cycle plus one cycle per data bit
	localparam int CNT_W = $clog2(`SB_DATA_WIDTH + 2);
	localparam logic [CNT_W-1:0] LOAD = CNT_W'(`SB_DATA_WIDTH + 1);

	logic [CNT_W-1:0] cnt;
	logic [`SB_DATA_WIDTH-1:0] shift_q;

	// counts down from LOAD, zero means idle
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			cnt <= '0;
		else if (resp_start)
			cnt <= LOAD;
		else if (cnt != '0)
			cnt <= cnt - 1'b1;
	end

	// shift after every data cycle, not after the valid cycle
	always_ff @(posedge clk)
	begin
		if (resp_start)
			shift_q <= resp_data;
		else if (cnt != '0 && cnt != LOAD)
			shift_q <= shift_q >> 1;
	end

	// header cycle right after resp_start
	assign rev_valid = (cnt == LOAD);
	// lsb first, don't care outside the data cycles
	assign rev_data_bit = shift_q[0];
	// covers the start cycle through the last bit
	assign resp_busy = resp_start || (cnt != '0);

	// a new read can't reach the memory before this reply is out
	assert property (@(posedge clk) disable iff (reset) resp_start |=> (!resp_start) [*9])
		else $error("slave_out_port: resp_start during a response");

endmodule

/* design/serial_bus_top.sv */
// serial bus top: master port, slave input port, slave memory, slave output port
`timescale 1ns/1ns
`include "serial_bus_defs.svh"

module serial_bus_top (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      host_req,
	input  serial_bus_pkg::host_cmd_t host_cmd,
	output logic                      host_ack,
	output logic [`SB_DATA_WIDTH-1:0] host_rdata
);

	import serial_bus_pkg::*;

	serial_fwd_t fwd;
	serial_rev_t rev;
	bus_frame_t frame;
	logic ready;
	logic rx_done;
	logic resp_start;
	logic resp_busy;
	logic rev_valid;
	logic rev_data_bit;
	logic [`SB_DATA_WIDTH-1:0] resp_data;

	// reverse lines come from two slave blocks
	assign rev = '{ready: ready, valid: rev_valid, data_bit: rev_data_bit};

	master_port master0 (.clk(clk), .reset(reset), .host_req(host_req),
		.host_cmd(host_cmd), .host_ack(host_ack), .host_rdata(host_rdata),
		.fwd(fwd), .rev(rev));

	slave_in_port slave_in0 (.clk(clk), .reset(reset), .fwd(fwd),
		.resp_busy(resp_busy), .ready(ready), .rx_done(rx_done), .frame(frame));

	slave_mem mem0 (.clk(clk), .reset(reset), .rx_done(rx_done), .frame(frame),
		.resp_start(resp_start), .resp_data(resp_data));

	slave_out_port slave_out0 (.clk(clk), .reset(reset), .resp_start(resp_start),
		.resp_data(resp_data), .resp_busy(resp_busy), .rev_valid(rev_valid),
		.rev_data_bit(rev_data_bit));

endmodule

/* verif/tb_serial_bus.sv */
// testbench for the serial bus: clock, reset, host transactions, reference memory, checks
`timescale 1ns/1ns
`include "serial_bus_defs.svh"

module tb_serial_bus;

	import serial_bus_pkg::*;

	// per-wait limit in clock cycles
	localparam int TIMEOUT = 200;

	logic clk;
	logic reset;
	logic host_req;
	host_cmd_t host_cmd;
	logic host_ack;
	logic [`SB_DATA_WIDTH-1:0] host_rdata;

	// reference copy of the slave memory, written alongside the DUT
	logic [`SB_DATA_WIDTH-1:0] ref_mem [`SB_MEM_DEPTH];
	logic [`SB_ADDR_WIDTH-1:0] wr_addrs [$];
	integer seed = 35;
	int pass_count = 0;
	int fail_count = 0;
	int test_errors = 0;
	int proto_errors = 0;
	bit seen_req = 1'b0;
	bit aborted = 1'b0;
	string test_name;

	serial_bus_top dut0 (.clk(clk), .reset(reset), .host_req(host_req),
		.host_cmd(host_cmd), .host_ack(host_ack), .host_rdata(host_rdata));

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// four-phase rules on the host side
	assert property (@(posedge clk) disable iff (reset) $rose(host_ack) |-> host_req)
		else begin
			$display("protocol error: host_ack rose while host_req low");
			proto_errors = proto_errors + 1;
		end
	assert property (@(posedge clk) disable iff (reset) $fell(host_ack) |-> !$past(host_req))
		else begin
			$display("protocol error: host_ack fell before host_req fell");
			proto_errors = proto_errors + 1;
		end
	assert property (@(posedge clk) disable iff (reset)
		host_ack && $past(host_ack) |-> $stable(host_rdata))
		else begin
			$display("protocol error: host_rdata changed while host_ack high");
			proto_errors = proto_errors + 1;
		end
	// nothing acked before the first request
	assert property (@(posedge clk) disable iff (reset) !seen_req |-> !host_ack)
		else begin
			$display("protocol error: host_ack high before any request");
			proto_errors = proto_errors + 1;
		end

	// closing summary, then the verdict
	task automatic end_run();
		$display("tests passed %0d failed %0d, protocol errors %0d",
			pass_count, fail_count, proto_errors);
		if (fail_count == 0 && proto_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	endtask

	// waits for host_ack to reach a level, checked once per edge
	task automatic wait_ack(input logic level, input string what);
		int n;
		n = 0;
		while (host_ack !== level && n < TIMEOUT)
		begin
			@(posedge clk);
			n = n + 1;
		end
		if (host_ack !== level)
		begin
			$display("timeout in %s: %s within %0d cycles", test_name, what, TIMEOUT);
			test_errors = test_errors + 1;
			aborted = 1'b1;
		end
	endtask

	// one full four-phase transaction
	task automatic run_txn(input bus_op_e op, input logic [`SB_ADDR_WIDTH-1:0] addr,
		input logic [`SB_DATA_WIDTH-1:0] data, output logic [`SB_DATA_WIDTH-1:0] rdata);
		// bus left alone once a wait has expired
		if (!aborted)
		begin
			@(posedge clk);
			host_cmd <= '{op: op, addr: addr, wdata: data};
			host_req <= 1'b1;
			seen_req <= 1'b1;
			wait_ack(1'b1, "host_ack did not rise");
			rdata = host_rdata;
			host_req <= 1'b0;
			wait_ack(1'b0, "host_ack did not fall");
		end
	endtask

	task automatic do_write(input logic [`SB_ADDR_WIDTH-1:0] addr,
		input logic [`SB_DATA_WIDTH-1:0] data);
		logic [`SB_DATA_WIDTH-1:0] unused;
		run_txn(OP_WRITE, addr, data, unused);
		ref_mem[addr] = data;
		wr_addrs.push_back(addr);
	endtask

	// read back and compare with the model
	task automatic do_read(input logic [`SB_ADDR_WIDTH-1:0] addr);
		logic [`SB_DATA_WIDTH-1:0] got;
		logic [`SB_DATA_WIDTH-1:0] exp;
		run_txn(OP_READ, addr, '0, got);
		exp = ref_mem[addr];
		if (!aborted)
		begin
			assert (got == exp)
			else begin
				$display("FAIL %s: addr %h expected %h actual %h", test_name, addr, exp, got);
				test_errors = test_errors + 1;
			end
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		if (aborted && test_errors == 0)
		begin
			fail_count = fail_count + 1;
			$display("test %s: not run, an earlier wait timed out", test_name);
		end
		else if (test_errors == 0)
		begin
			pass_count = pass_count + 1;
			$display("test %s: ok", test_name);
		end
		else
		begin
			fail_count = fail_count + 1;
			$display("test %s: %0d errors", test_name, test_errors);
		end
		test_errors = 0;
	endtask

	initial
	begin
		logic [`SB_DATA_WIDTH-1:0] pat [4];
		logic [`SB_ADDR_WIDTH-1:0] ends [2];
		int r;
		int idx;
		pat = '{8'h00, 8'hFF, 8'hA5, 8'h5A};
		ends = '{12'h000, 12'hFFF};
		reset = 1'b1;
		host_req = 1'b0;
		host_cmd = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		// idle bus after reset
		start_test("reset_idle");
		repeat (10)
		begin
			@(posedge clk);
			assert (host_ack == 1'b0)
			else begin
				$display("host_ack high after reset without a request");
				test_errors = test_errors + 1;
			end
		end
		finish_test();

		start_test("write_read");
		do_write(12'h123, 8'h35);
		do_read(12'h123);
		finish_test();

		// both ends of the address range, all patterns
		start_test("edge_patterns");
		for (int a = 0; a < 2; a++)
		begin
			for (int p = 0; p < 4; p++)
			begin
				do_write(ends[a], pat[p]);
				do_read(ends[a]);
			end
		end
		finish_test();

		start_test("overwrite");
		do_write(12'h7A1, 8'h11);
		do_write(12'h7A1, 8'hE2);
		do_read(12'h7A1);
		finish_test();

		// reads only hit addresses already written
		start_test("random_ops");
		for (int i = 0; i < 30; i++)
		begin
			r = $random(seed);
			if (r[0] && wr_addrs.size() != 0)
			begin
				idx = $unsigned($random(seed)) % wr_addrs.size();
				do_read(wr_addrs[idx]);
			end
			else
			begin
				r = $random(seed);
				do_write(r[`SB_ADDR_WIDTH-1:0], r[`SB_ADDR_WIDTH+`SB_DATA_WIDTH-1:`SB_ADDR_WIDTH]);
			end
		end
		finish_test();

		repeat (5) @(posedge clk);
		end_run();
	end

endmodule

/* verilog.f */
+incdir+design
design/serial_bus_pkg.sv
design/master_port.sv
design/slave_in_port.sv
design/slave_mem.sv
design/slave_out_port.sv
design/serial_bus_top.sv
verif/tb_serial_bus.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the serial bus testbench with Verilator

TOP=tb_serial_bus
LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -qF ">>> FAIL" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if ! grep -qF ">>> PASS" "$LOG"; then
	echo "simulation ended without a verdict"
	exit 1
fi

exit 0
